// ==== src.f ====
src/pw_pkg.sv
src/reg_file.sv
src/rx_event_source.sv
src/capture_arbiter.sv
src/capture_fifo.sv
src/pattern_matcher.sv
src/trigger_gen.sv
src/sniffer_top.sv
verif/tb_sniffer.sv

// ==== Makefile ====
# Verilator flow for the USB sniffer core

TOP = tb_sniffer

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f src.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// ==== verif/tb_sniffer.sv ====
`timescale 1ns/100ps

module tb_sniffer;

   localparam int FIFO_DEPTH = 16;

   // rough cycle budget of each test
   localparam int T_RESET     = 12;
   localparam int T_REGS      = 80;
   localparam int T_CAPTURE   = 140;
   localparam int T_LIMITS    = 330;
   localparam int T_TRIGGER   = 180;
   localparam int CYCLE_LIMIT = 2 * (T_RESET + T_REGS + T_CAPTURE + T_LIMITS + T_TRIGGER);

   logic        clk;
   logic        rst_n;
   logic [7:0]  reg_addr;
   logic [7:0]  reg_wdata;
   logic        reg_write;
   logic        reg_read;
   logic [7:0]  reg_rdata;
   logic [7:0]  fe_data;
   logic        fe_rxvalid;
   logic        fe_rxactive;
   logic        fe_rxerror;
   logic        fe_sessvld;
   logic        fe_sessend;
   logic        fe_vbusvld;
   logic [1:0]  fe_xcvrsel;
   logic        fe_termsel;
   logic        trig;

   logic [15:0] lfsr_q;
   int          cycle = 0;
   int          win_lo;       // expected trigger window, empty when lo > hi
   int          win_hi;
   int          err_at;       // byte index that raises rxerror, -1 for none
   logic [7:0]  trig_delay;
   logic [7:0]  trig_width;
   logic [7:0]  tx_bytes [$];
   logic [17:0] entries [$];   // read back from the capture memory

   sniffer_top #(.FIFO_DEPTH(FIFO_DEPTH), .PATTERN_BYTES(4)) dut0 (
      .fe_clk_i(clk), .rst_n_i(rst_n),
      .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata),
      .reg_write_i(reg_write), .reg_read_i(reg_read), .reg_rdata_o(reg_rdata),
      .fe_data_i(fe_data), .fe_rxvalid_i(fe_rxvalid), .fe_rxactive_i(fe_rxactive),
      .fe_rxerror_i(fe_rxerror), .fe_sessvld_i(fe_sessvld),
      .fe_sessend_i(fe_sessend), .fe_vbusvld_i(fe_vbusvld),
      .fe_xcvrsel_o(fe_xcvrsel), .fe_termsel_o(fe_termsel), .trig_o(trig)
   );

   always #4 clk = ~clk;

   always @(posedge clk) cycle <= cycle + 1;

   //////////////////////////////////////////////////////////////////////
   // checking helpers
   //////////////////////////////////////////////////////////////////////
   task automatic end_with_failure();
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("mismatch %s: got %h expected %h", name, got, exp);
         end_with_failure();
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      assert (cond) else begin
         $display("%s", what);
         end_with_failure();
      end
   endtask

   always @(posedge clk) begin
      if (cycle >= CYCLE_LIMIT) begin
         $display("timeout, run went past %0d cycles", CYCLE_LIMIT);
         end_with_failure();
      end
   end

   // trig_o must sit high exactly inside the predicted window
   a_trig_window: assert property (@(negedge clk) disable iff (!rst_n)
      trig == (cycle >= win_lo && cycle <= win_hi))
   else begin
      $display("mismatch trig_o: got %h expected %h", trig, !trig);
      end_with_failure();
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus helpers
   //////////////////////////////////////////////////////////////////////
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic draw_bits(input int n, output logic [7:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);   // one step per bit
         v = {v[6:0], lfsr_q[0]};
      end
   endtask

   function automatic logic [2:0] pins_for_speed(input logic [1:0] code);
      case (code)
         pw_pkg::SPEED_LS: pins_for_speed = 3'b10_1;
         pw_pkg::SPEED_HS: pins_for_speed = 3'b00_0;
         default:          pins_for_speed = 3'b01_1;  // full speed, code 3 too
      endcase
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   task automatic reg_wr(input logic [7:0] addr, input logic [7:0] data);
      @(posedge clk);
      reg_addr  <= addr;
      reg_wdata <= data;
      reg_write <= 1'b1;
      @(posedge clk);
      reg_write <= 1'b0;
   endtask

   task automatic reg_rd(input logic [7:0] addr, output logic [7:0] data);
      @(posedge clk);
      reg_addr <= addr;
      reg_read <= 1'b1;
      @(posedge clk);
      reg_read <= 1'b0;
      @(negedge clk);   // rdata registered at the edge before
      data = reg_rdata;
   endtask

   task automatic make_packet(input int n, input logic [7:0] keep);
      logic [7:0] b;
      tx_bytes.delete();
      for (int i = 0; i < n; i++) begin
         draw_bits(8, b);
         tx_bytes.push_back(b & keep);
      end
   endtask

   // byte at index mark opens the trigger window, -1 for none
   task automatic send_packet(input int mark);
      logic [7:0] gap;
      @(posedge clk);
      fe_rxactive <= 1'b1;
      foreach (tx_bytes[i]) begin
         draw_bits(2, gap);
         repeat (gap) begin
            @(posedge clk);
            fe_rxvalid <= 1'b0;
         end
         @(posedge clk);
         fe_data    <= tx_bytes[i];
         fe_rxvalid <= 1'b1;
         fe_rxerror <= (i == err_at);
         if (i == mark) begin
            win_lo = cycle + 3 + int'(trig_delay);
            win_hi = cycle + 2 + int'(trig_delay) + int'(trig_width);
         end
      end
      @(posedge clk);
      fe_rxvalid <= 1'b0;
      fe_rxerror <= 1'b0;
      @(posedge clk);
      fe_rxactive <= 1'b0;
   endtask

   task automatic drain_fifo();
      logic [7:0] st;
      logic [7:0] b0;
      logic [7:0] b1;
      logic [7:0] b2;
      entries.delete();
      reg_rd(pw_pkg::ADDR_FIFO_STAT, st);
      while (!st[0]) begin
         reg_rd(pw_pkg::ADDR_FIFO_B0, b0);
         reg_rd(pw_pkg::ADDR_FIFO_B1, b1);
         reg_rd(pw_pkg::ADDR_FIFO_B2, b2);   // pops the head
         entries.push_back({b2[1:0], b1, b0});
         reg_rd(pw_pkg::ADDR_FIFO_STAT, st);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // tests
   //////////////////////////////////////////////////////////////////////
   initial begin
      logic [7:0] cfg_addr [12];
      logic [7:0] cfg_val [12];
      logic [7:0] rd;
      logic [7:0] b;
      logic [7:0] bytes_seen [$];
      logic [7:0] last_ts;
      logic [4:0] new_stat;
      int         stat_hits;
      int         mark;

      clk = 1'b0;
      lfsr_q = 16'd24826;
      win_lo = 1;
      win_hi = 0;
      err_at = -1;
      trig_delay = 8'd0;
      trig_width = 8'd0;
      rst_n       <= 1'b0;
      reg_addr    <= 8'd0;
      reg_wdata   <= 8'd0;
      reg_write   <= 1'b0;
      reg_read    <= 1'b0;
      fe_data     <= 8'd0;
      fe_rxvalid  <= 1'b0;
      fe_rxactive <= 1'b0;
      fe_rxerror  <= 1'b0;
      fe_sessvld  <= 1'b1;
      fe_sessend  <= 1'b0;
      fe_vbusvld  <= 1'b1;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;

      // register read back and speed pins
      reg_rd(pw_pkg::ADDR_FIFO_STAT, rd);
      check_eq("reg_rdata_o fifo_stat", rd, 8'h01);
      check_eq("fe_xcvrsel_o/fe_termsel_o", {fe_xcvrsel, fe_termsel},
               pins_for_speed(pw_pkg::SPEED_FS));
      for (int i = 0; i < 12; i++) begin
         if (i < 9)
            cfg_addr[i] = pw_pkg::ADDR_PATTERN0 + 8'(i);   // pattern, mask, length
         else
            cfg_addr[i] = pw_pkg::ADDR_TRIG_DELAY + 8'(i - 9);
         draw_bits(8, cfg_val[i]);
         reg_wr(cfg_addr[i], cfg_val[i]);
      end
      for (int i = 0; i < 12; i++) begin
         reg_rd(cfg_addr[i], rd);
         check_eq($sformatf("reg_rdata_o at 0x%h", cfg_addr[i]), rd, cfg_val[i]);
      end
      for (int s = 0; s < 4; s++) begin
         reg_wr(pw_pkg::ADDR_SPEED, 8'(s));
         @(negedge clk);
         check_eq("fe_xcvrsel_o/fe_termsel_o", {fe_xcvrsel, fe_termsel}, pins_for_speed(2'(s)));
         reg_rd(pw_pkg::ADDR_SPEED, rd);
         check_eq("reg_rdata_o speed", rd, 8'(s));
      end
      reg_wr(pw_pkg::ADDR_PAT_BYTES, 8'd0);   // no matching until the trigger test
      reg_wr(pw_pkg::ADDR_CAP_LEN, 8'd0);

      // packet capture plus one sessvld change
      reg_wr(pw_pkg::ADDR_ARM, 8'h01);
      wait_cycles(4);
      make_packet(8, 8'hFF);
      send_packet(-1);
      wait_cycles(4);
      @(posedge clk);
      fe_sessvld <= 1'b0;
      new_stat = {1'b0, 1'b0, 1'b0, 1'b0, 1'b1};   // rxactive .. vbusvld
      wait_cycles(4);
      drain_fifo();
      stat_hits = 0;
      last_ts = 8'd0;
      foreach (entries[i]) begin
         if (entries[i][17:16] == pw_pkg::CMD_DATA) begin
            check_true(entries[i][15:8] >= last_ts, "data entry timestamps go backwards");
            last_ts = entries[i][15:8];
            bytes_seen.push_back(entries[i][7:0]);
         end else begin
            check_true(entries[i][17:16] == pw_pkg::CMD_STAT, "entry has an unknown command");
            if (entries[i][4:0] == new_stat) begin
               stat_hits++;
               check_true(entries[i][15:8] >= last_ts,
                          "status entry stamped before the data entry ahead of it");
            end
         end
      end
      check_eq("data entry count", bytes_seen.size(), tx_bytes.size());
      foreach (tx_bytes[i]) begin
         check_eq("captured byte", bytes_seen[i], tx_bytes[i]);
      end
      check_eq("sessvld status entries", stat_hits, 1);
      @(posedge clk);
      fe_sessvld <= 1'b1;

      // capture length limit, then memory overflow
      reg_wr(pw_pkg::ADDR_CAP_LEN, 8'd5);
      reg_wr(pw_pkg::ADDR_ARM, 8'h01);
      wait_cycles(4);
      make_packet(10, 8'hFF);
      send_packet(-1);
      wait_cycles(2);
      reg_rd(pw_pkg::ADDR_FIFO_STAT, rd);
      check_eq("reg_rdata_o fifo_stat", rd, 8'h00);   // armed dropped
      drain_fifo();
      check_eq("stored entries", entries.size(), 5);
      reg_wr(pw_pkg::ADDR_CAP_LEN, 8'd0);
      reg_wr(pw_pkg::ADDR_ARM, 8'h01);
      wait_cycles(4);
      make_packet(FIFO_DEPTH + 4, 8'hFF);
      err_at = 2;   // status edges collide with byte events
      send_packet(-1);
      err_at = -1;
      wait_cycles(2);
      reg_rd(pw_pkg::ADDR_FIFO_STAT, rd);
      check_eq("reg_rdata_o fifo_stat", rd, 8'h0E);
      drain_fifo();
      check_eq("stored entries", entries.size(), FIFO_DEPTH);
      reg_rd(pw_pkg::ADDR_FIFO_STAT, rd);
      check_eq("reg_rdata_o fifo_stat", rd, 8'h0D);

      // masked pattern A5 3x 7E, newest byte first in the registers
      trig_delay = 8'd3;
      trig_width = 8'd4;
      reg_wr(pw_pkg::ADDR_PATTERN0, 8'h7E);
      reg_wr(pw_pkg::ADDR_PATTERN0 + 8'd1, 8'h30);
      reg_wr(pw_pkg::ADDR_PATTERN0 + 8'd2, 8'hA5);
      reg_wr(pw_pkg::ADDR_MASK0, 8'hFF);
      reg_wr(pw_pkg::ADDR_MASK0 + 8'd1, 8'hF0);
      reg_wr(pw_pkg::ADDR_MASK0 + 8'd2, 8'hFF);
      reg_wr(pw_pkg::ADDR_PAT_BYTES, 8'd3);
      reg_wr(pw_pkg::ADDR_TRIG_DELAY, trig_delay);
      reg_wr(pw_pkg::ADDR_TRIG_WIDTH, trig_width);
      reg_wr(pw_pkg::ADDR_ARM, 8'h01);
      wait_cycles(4);
      make_packet(8, 8'h0F);   // low nibble only, never matches
      send_packet(-1);
      wait_cycles(20);
      make_packet(3, 8'h0F);
      tx_bytes.push_back(8'hA5);
      tx_bytes.push_back(8'h3C);
      tx_bytes.push_back(8'h7E);
      mark = tx_bytes.size() - 1;
      draw_bits(8, b);
      tx_bytes.push_back(b & 8'h0F);
      send_packet(mark);
      wait_cycles(int'(trig_delay) + int'(trig_width) + 8);
      send_packet(-1);   // same pattern again, one trigger per arm
      wait_cycles(20);

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// ==== src/sniffer_top.sv ====
`timescale 1ns/100ps

module sniffer_top #(
   parameter int FIFO_DEPTH    = 16,
   parameter int PATTERN_BYTES = 4
) (
   input  logic       fe_clk_i,
   input  logic       rst_n_i,
   input  logic [7:0] reg_addr_i,
   input  logic [7:0] reg_wdata_i,
   input  logic       reg_write_i,
   input  logic       reg_read_i,
   output logic [7:0] reg_rdata_o,
   input  logic [7:0] fe_data_i,
   input  logic       fe_rxvalid_i,
   input  logic       fe_rxactive_i,
   input  logic       fe_rxerror_i,
   input  logic       fe_sessvld_i,
   input  logic       fe_sessend_i,
   input  logic       fe_vbusvld_i,
   output logic [1:0] fe_xcvrsel_o,
   output logic       fe_termsel_o,
   output logic       trig_o
);

   logic                       armed, arm_start, fifo_pop, cap_done;
   logic                       fifo_empty, fifo_full, fifo_overflow;
   logic [PATTERN_BYTES*8-1:0] pattern, mask;
   logic [7:0]                 pat_bytes, trig_delay, trig_width, cap_len;
   logic                       byte_evt, stat_evt, wr, match;
   pw_pkg::capture_entry_t     fifo_head, byte_entry, stat_entry, wr_entry;

   //////////////////////////////////////////////////////////////////////
   // control
   //////////////////////////////////////////////////////////////////////
   reg_file #(.PATTERN_BYTES(PATTERN_BYTES)) u_reg_file (
      .fe_clk_i(fe_clk_i), .rst_n_i(rst_n_i),
      .reg_addr_i(reg_addr_i), .reg_wdata_i(reg_wdata_i),
      .reg_write_i(reg_write_i), .reg_read_i(reg_read_i),
      .fifo_head_i(fifo_head), .fifo_empty_i(fifo_empty),
      .fifo_full_i(fifo_full), .fifo_overflow_i(fifo_overflow),
      .cap_done_i(cap_done), .reg_rdata_o(reg_rdata_o),
      .armed_o(armed), .arm_start_o(arm_start), .fifo_pop_o(fifo_pop),
      .pattern_o(pattern), .mask_o(mask), .pat_bytes_o(pat_bytes),
      .trig_delay_o(trig_delay), .trig_width_o(trig_width), .cap_len_o(cap_len),
      .fe_xcvrsel_o(fe_xcvrsel_o), .fe_termsel_o(fe_termsel_o)
   );

   //////////////////////////////////////////////////////////////////////
   // capture path
   //////////////////////////////////////////////////////////////////////
   rx_event_source u_rx_event_source (
      .fe_clk_i(fe_clk_i), .rst_n_i(rst_n_i), .arm_start_i(arm_start),
      .fe_data_i(fe_data_i), .fe_rxvalid_i(fe_rxvalid_i),
      .fe_rxactive_i(fe_rxactive_i), .fe_rxerror_i(fe_rxerror_i),
      .fe_sessvld_i(fe_sessvld_i), .fe_sessend_i(fe_sessend_i),
      .fe_vbusvld_i(fe_vbusvld_i),
      .byte_evt_o(byte_evt), .byte_entry_o(byte_entry),
      .stat_evt_o(stat_evt), .stat_entry_o(stat_entry)
   );

   capture_arbiter u_capture_arbiter (
      .fe_clk_i(fe_clk_i), .rst_n_i(rst_n_i),
      .byte_evt_i(byte_evt), .byte_entry_i(byte_entry),
      .stat_evt_i(stat_evt), .stat_entry_i(stat_entry),
      .wr_o(wr), .wr_entry_o(wr_entry)
   );

   capture_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_capture_fifo (
      .fe_clk_i(fe_clk_i), .rst_n_i(rst_n_i),
      .armed_i(armed), .arm_start_i(arm_start),
      .wr_i(wr), .wr_entry_i(wr_entry), .pop_i(fifo_pop), .cap_len_i(cap_len),
      .head_o(fifo_head), .empty_o(fifo_empty), .full_o(fifo_full),
      .overflow_o(fifo_overflow), .cap_done_o(cap_done)
   );

   //////////////////////////////////////////////////////////////////////
   // trigger path
   //////////////////////////////////////////////////////////////////////
   pattern_matcher #(.PATTERN_BYTES(PATTERN_BYTES)) u_pattern_matcher (
      .fe_clk_i(fe_clk_i), .rst_n_i(rst_n_i), .armed_i(armed),
      .fe_data_i(fe_data_i), .fe_rxvalid_i(fe_rxvalid_i),
      .fe_rxactive_i(fe_rxactive_i),
      .pattern_i(pattern), .mask_i(mask), .pat_bytes_i(pat_bytes),
      .match_o(match)
   );

   trigger_gen u_trigger_gen (
      .fe_clk_i(fe_clk_i), .rst_n_i(rst_n_i), .match_i(match),
      .trig_delay_i(trig_delay), .trig_width_i(trig_width),
      .trig_o(trig_o)
   );

endmodule

// ==== src/trigger_gen.sv ====
`timescale 1ns/100ps

module trigger_gen (
   input  logic       fe_clk_i,
   input  logic       rst_n_i,
   input  logic       match_i,
   input  logic [7:0] trig_delay_i,
   input  logic [7:0] trig_width_i,
   output logic       trig_o
);

   logic       delaying_q;
   logic [7:0] dcnt_q;   // delay cycles still to go
   logic [7:0] wcnt_q;   // pulse cycles still to go

   // pulse covers m+delay+1 .. m+delay+width
   always_ff @(posedge fe_clk_i) begin
      if (!rst_n_i) begin
         delaying_q <= 1'b0;
         trig_o     <= 1'b0;
         dcnt_q     <= '0;
         wcnt_q     <= '0;
      end else if (delaying_q) begin
         if (dcnt_q == 8'd0) begin
            delaying_q <= 1'b0;
            trig_o     <= 1'b1;
            wcnt_q     <= trig_width_i - 1'b1;
         end else begin
            dcnt_q <= dcnt_q - 1'b1;
         end
      end else if (trig_o) begin
         if (wcnt_q == 8'd0)
            trig_o <= 1'b0;
         else
            wcnt_q <= wcnt_q - 1'b1;
      end else if (match_i && trig_width_i != 8'd0) begin
         if (trig_delay_i == 8'd0) begin
            trig_o <= 1'b1;
            wcnt_q <= trig_width_i - 1'b1;
         end else begin
            delaying_q <= 1'b1;
            dcnt_q     <= trig_delay_i - 1'b1;
         end
      end
   end

   // matcher fires once per arm, so no retrigger mid pulse
   a_no_retrigger: assert property (@(posedge fe_clk_i) disable iff (!rst_n_i)
      match_i |-> !(delaying_q || trig_o));

endmodule

// ==== src/pattern_matcher.sv ====
`timescale 1ns/100ps

module pattern_matcher #(
   parameter int PATTERN_BYTES = 4
) (
   input  logic                       fe_clk_i,
   input  logic                       rst_n_i,
   input  logic                       armed_i,
   input  logic [7:0]                 fe_data_i,
   input  logic                       fe_rxvalid_i,
   input  logic                       fe_rxactive_i,
   input  logic [PATTERN_BYTES*8-1:0] pattern_i,
   input  logic [PATTERN_BYTES*8-1:0] mask_i,
   input  logic [7:0]                 pat_bytes_i,
   output logic                       match_o
);

   localparam int CW = $clog2(PATTERN_BYTES + 1);

   logic [7:0]    hist_q [PATTERN_BYTES];  // byte 0 is the newest
   logic [7:0]    nxt [PATTERN_BYTES];
   logic [CW-1:0] cnt_q;
   logic [CW-1:0] nxt_cnt;
   logic          valid;
   logic          hit;
   logic          fired_q;   // one match per arm

   assign valid   = fe_rxvalid_i && fe_rxactive_i;
   assign nxt_cnt = (cnt_q == CW'(PATTERN_BYTES)) ? cnt_q : cnt_q + 1'b1;

   // compare against the history as it will be after this byte
   always_comb begin
      nxt[0] = fe_data_i;
      for (int i = 1; i < PATTERN_BYTES; i++)
         nxt[i] = hist_q[i-1];
      hit = (pat_bytes_i != 8'd0) && (8'(nxt_cnt) >= pat_bytes_i);
      for (int i = 0; i < PATTERN_BYTES; i++) begin
         if (8'(i) < pat_bytes_i &&
             ((nxt[i] ^ pattern_i[8*i +: 8]) & mask_i[8*i +: 8]) != 8'd0)
            hit = 1'b0;
      end
   end

   always_ff @(posedge fe_clk_i) begin
      if (!rst_n_i) begin
         cnt_q   <= '0;
         match_o <= 1'b0;
         fired_q <= 1'b0;
      end else begin
         match_o <= 1'b0;
         if (!fe_rxactive_i)
            cnt_q <= '0;      // packet over, history gone
         else if (valid)
            cnt_q <= nxt_cnt;
         if (!armed_i) begin
            fired_q <= 1'b0;
         end else if (valid && hit && !fired_q) begin
            match_o <= 1'b1;
            fired_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge fe_clk_i) begin
      if (valid)
         hist_q <= nxt;
   end

endmodule

// ==== src/capture_fifo.sv ====
`timescale 1ns/100ps

module capture_fifo #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic                   fe_clk_i,
   input  logic                   rst_n_i,
   input  logic                   armed_i,
   input  logic                   arm_start_i,
   input  logic                   wr_i,
   input  pw_pkg::capture_entry_t wr_entry_i,
   input  logic                   pop_i,
   input  logic [7:0]             cap_len_i,
   output pw_pkg::capture_entry_t head_o,
   output logic                   empty_o,
   output logic                   full_o,
   output logic                   overflow_o,
   output logic                   cap_done_o
);

   localparam int AW = $clog2(FIFO_DEPTH);

   pw_pkg::capture_entry_t mem [FIFO_DEPTH];
   logic [AW-1:0]          wptr_q;
   logic [AW-1:0]          rptr_q;
   logic [AW:0]            count_q;
   logic [7:0]             wr_cnt_q;   // entries written since arm
   logic                   do_wr;
   logic                   do_pop;

   assign empty_o = count_q == '0;
   assign full_o  = count_q == (AW+1)'(FIFO_DEPTH);
   assign head_o  = mem[rptr_q];
   assign do_wr   = wr_i && armed_i && !full_o;
   assign do_pop  = pop_i && !empty_o;

   // combinational so armed drops before one more entry slips in
   assign cap_done_o = do_wr && (cap_len_i != 8'd0) && (wr_cnt_q + 8'd1 == cap_len_i);

   //////////////////////////////////////////////////////////////////////
   // pointers and flags
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge fe_clk_i) begin
      if (!rst_n_i || arm_start_i) begin
         wptr_q     <= '0;
         rptr_q     <= '0;
         count_q    <= '0;
         wr_cnt_q   <= '0;
         overflow_o <= 1'b0;
      end else begin
         if (do_wr) begin
            wptr_q   <= wptr_q + 1'b1;
            wr_cnt_q <= wr_cnt_q + 1'b1;
         end
         if (do_pop)
            rptr_q <= rptr_q + 1'b1;
         if (do_wr && !do_pop)
            count_q <= count_q + 1'b1;
         else if (do_pop && !do_wr)
            count_q <= count_q - 1'b1;
         if (wr_i && armed_i && full_o)
            overflow_o <= 1'b1;   // entry dropped
      end
   end

   always_ff @(posedge fe_clk_i) begin
      if (do_wr)
         mem[wptr_q] <= wr_entry_i;
   end

   // count stays in range and agrees with the pointer distance
   a_count_bound: assert property (@(posedge fe_clk_i) disable iff (!rst_n_i)
      count_q <= (AW+1)'(FIFO_DEPTH) && count_q[AW-1:0] == wptr_q - rptr_q);

endmodule

// ==== src/capture_arbiter.sv ====
`timescale 1ns/100ps

module capture_arbiter (
   input  logic                   fe_clk_i,
   input  logic                   rst_n_i,
   input  logic                   byte_evt_i,
   input  pw_pkg::capture_entry_t byte_entry_i,
   input  logic                   stat_evt_i,
   input  pw_pkg::capture_entry_t stat_entry_i,
   output logic                   wr_o,
   output pw_pkg::capture_entry_t wr_entry_o
);

   logic                   pend_vld;
   pw_pkg::capture_entry_t pend_entry;

   // bytes first, then the newest status, then the parked one
   always_comb begin
      wr_o = byte_evt_i || stat_evt_i || pend_vld;
      if (byte_evt_i)
         wr_entry_o = byte_entry_i;
      else if (stat_evt_i)
         wr_entry_o = stat_entry_i;
      else
         wr_entry_o = pend_entry;
   end

   always_ff @(posedge fe_clk_i) begin
      if (!rst_n_i)
         pend_vld <= 1'b0;
      else if (!byte_evt_i)
         pend_vld <= 1'b0;    // slot drained or superseded
      else if (stat_evt_i)
         pend_vld <= 1'b1;
   end

   always_ff @(posedge fe_clk_i) begin
      if (byte_evt_i && stat_evt_i)
         pend_entry <= stat_entry_i;   // newer status replaces old
   end

   // the parked status leaves through the port as a status entry
   a_pend_held: assert property (@(posedge fe_clk_i) disable iff (!rst_n_i)
      pend_vld && !byte_evt_i |-> wr_o && wr_entry_o.status.cmd == pw_pkg::CMD_STAT);

endmodule

// ==== src/rx_event_source.sv ====
`timescale 1ns/100ps

module rx_event_source (
   input  logic                   fe_clk_i,
   input  logic                   rst_n_i,
   input  logic                   arm_start_i,
   input  logic [7:0]             fe_data_i,
   input  logic                   fe_rxvalid_i,
   input  logic                   fe_rxactive_i,
   input  logic                   fe_rxerror_i,
   input  logic                   fe_sessvld_i,
   input  logic                   fe_sessend_i,
   input  logic                   fe_vbusvld_i,
   output logic                   byte_evt_o,
   output pw_pkg::capture_entry_t byte_entry_o,
   output logic                   stat_evt_o,
   output pw_pkg::capture_entry_t stat_entry_o
);

   logic [pw_pkg::TS_WIDTH-1:0]   ts_q;
   logic [pw_pkg::STAT_WIDTH-1:0] stat_now;
   logic [pw_pkg::STAT_WIDTH-1:0] stat_q;

   assign stat_now = {fe_rxactive_i, fe_rxerror_i, fe_sessvld_i, fe_sessend_i, fe_vbusvld_i};

   // free running, restarts with each arm
   always_ff @(posedge fe_clk_i) begin
      if (!rst_n_i || arm_start_i)
         ts_q <= '0;
      else
         ts_q <= ts_q + 1'b1;
   end

   always_ff @(posedge fe_clk_i) begin
      if (!rst_n_i) begin
         byte_evt_o <= 1'b0;
         stat_evt_o <= 1'b0;
         stat_q     <= '0;
      end else begin
         byte_evt_o <= fe_rxvalid_i && fe_rxactive_i;
         stat_evt_o <= stat_now != stat_q;   // any line status edge
         stat_q     <= stat_now;
      end
   end

   // entries carry the timestamp of the cycle the event was seen
   always_ff @(posedge fe_clk_i) begin
      byte_entry_o.data.cmd     <= pw_pkg::CMD_DATA;
      byte_entry_o.data.ts      <= ts_q;
      byte_entry_o.data.rx_byte <= fe_data_i;
      stat_entry_o.status.cmd   <= pw_pkg::CMD_STAT;
      stat_entry_o.status.ts    <= ts_q;
      stat_entry_o.status.pad   <= 3'd0;
      stat_entry_o.status.stat  <= stat_now;
   end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/100ps

module reg_file #(
   parameter int PATTERN_BYTES = 4
) (
   input  logic                       fe_clk_i,
   input  logic                       rst_n_i,
   input  logic [7:0]                 reg_addr_i,
   input  logic [7:0]                 reg_wdata_i,
   input  logic                       reg_write_i,
   input  logic                       reg_read_i,
   input  pw_pkg::capture_entry_t     fifo_head_i,
   input  logic                       fifo_empty_i,
   input  logic                       fifo_full_i,
   input  logic                       fifo_overflow_i,
   input  logic                       cap_done_i,
   output logic [7:0]                 reg_rdata_o,
   output logic                       armed_o,
   output logic                       arm_start_o,
   output logic                       fifo_pop_o,
   output logic [PATTERN_BYTES*8-1:0] pattern_o,
   output logic [PATTERN_BYTES*8-1:0] mask_o,
   output logic [7:0]                 pat_bytes_o,
   output logic [7:0]                 trig_delay_o,
   output logic [7:0]                 trig_width_o,
   output logic [7:0]                 cap_len_o,
   output logic [1:0]                 fe_xcvrsel_o,
   output logic                       fe_termsel_o
);

   logic [1:0] speed_q;
   logic [7:0] rd_mux;
   logic       arm_wr;

   assign arm_wr     = reg_write_i && (reg_addr_i == pw_pkg::ADDR_ARM);
   assign fifo_pop_o = reg_read_i && (reg_addr_i == pw_pkg::ADDR_FIFO_B2);

   //////////////////////////////////////////////////////////////////////
   // configuration registers
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge fe_clk_i) begin
      if (!rst_n_i) begin
         speed_q      <= pw_pkg::SPEED_FS;
         pattern_o    <= '0;
         mask_o       <= '0;
         pat_bytes_o  <= '0;
         trig_delay_o <= '0;
         trig_width_o <= '0;
         cap_len_o    <= '0;  // 0 = no length limit
      end else if (reg_write_i) begin
         case (reg_addr_i)
            pw_pkg::ADDR_SPEED:      speed_q      <= reg_wdata_i[1:0];
            pw_pkg::ADDR_PAT_BYTES:  pat_bytes_o  <= reg_wdata_i;
            pw_pkg::ADDR_TRIG_DELAY: trig_delay_o <= reg_wdata_i;
            pw_pkg::ADDR_TRIG_WIDTH: trig_width_o <= reg_wdata_i;
            pw_pkg::ADDR_CAP_LEN:    cap_len_o    <= reg_wdata_i;
            default: ;
         endcase
         for (int i = 0; i < PATTERN_BYTES; i++) begin
            if (reg_addr_i == pw_pkg::ADDR_PATTERN0 + 8'(i))
               pattern_o[8*i +: 8] <= reg_wdata_i;
            if (reg_addr_i == pw_pkg::ADDR_MASK0 + 8'(i))
               mask_o[8*i +: 8] <= reg_wdata_i;
         end
      end
   end

   // arm state, start pulse lines up with armed rising
   always_ff @(posedge fe_clk_i) begin
      if (!rst_n_i) begin
         armed_o     <= 1'b0;
         arm_start_o <= 1'b0;
      end else begin
         arm_start_o <= arm_wr && reg_wdata_i[0];
         if (arm_wr)
            armed_o <= reg_wdata_i[0];
         else if (cap_done_i)
            armed_o <= 1'b0;   // capture length reached
      end
   end

   //////////////////////////////////////////////////////////////////////
   // read back
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      case (reg_addr_i)
         pw_pkg::ADDR_ARM:        rd_mux = {7'd0, armed_o};
         pw_pkg::ADDR_SPEED:      rd_mux = {6'd0, speed_q};
         pw_pkg::ADDR_PAT_BYTES:  rd_mux = pat_bytes_o;
         pw_pkg::ADDR_TRIG_DELAY: rd_mux = trig_delay_o;
         pw_pkg::ADDR_TRIG_WIDTH: rd_mux = trig_width_o;
         pw_pkg::ADDR_CAP_LEN:    rd_mux = cap_len_o;
         pw_pkg::ADDR_FIFO_B0:    rd_mux = fifo_head_i[7:0];
         pw_pkg::ADDR_FIFO_B1:    rd_mux = fifo_head_i[15:8];
         pw_pkg::ADDR_FIFO_B2:    rd_mux = {6'd0, fifo_head_i[pw_pkg::ENTRY_WIDTH-1:16]};
         pw_pkg::ADDR_FIFO_STAT:
            rd_mux = {4'd0, armed_o, fifo_overflow_i, fifo_full_i, fifo_empty_i};
         default:                 rd_mux = 8'd0;
      endcase
      for (int i = 0; i < PATTERN_BYTES; i++) begin
         if (reg_addr_i == pw_pkg::ADDR_PATTERN0 + 8'(i))
            rd_mux = pattern_o[8*i +: 8];
         if (reg_addr_i == pw_pkg::ADDR_MASK0 + 8'(i))
            rd_mux = mask_o[8*i +: 8];
      end
   end

   always_ff @(posedge fe_clk_i) begin
      if (reg_read_i)
         reg_rdata_o <= rd_mux;
   end

   // transceiver and termination select from programmed speed
   always_comb begin
      case (speed_q)
         pw_pkg::SPEED_LS: {fe_xcvrsel_o, fe_termsel_o} = 3'b10_1;
         pw_pkg::SPEED_HS: {fe_xcvrsel_o, fe_termsel_o} = 3'b00_0;
         default:          {fe_xcvrsel_o, fe_termsel_o} = 3'b01_1;
      endcase
   end

   // host software must check FIFO_STAT before draining
   a_pop_not_empty: assert property (@(posedge fe_clk_i) disable iff (!rst_n_i)
      fifo_pop_o |-> !fifo_empty_i);

endmodule

// ==== src/pw_pkg.sv ====
package pw_pkg;

   //////////////////////////////////////////////////////////////////////
   // widths
   //////////////////////////////////////////////////////////////////////
   localparam int TS_WIDTH    = 8;
   localparam int STAT_WIDTH  = 5;   // rxactive, rxerror, sessvld, sessend, vbusvld
   localparam int ENTRY_WIDTH = 18;

   localparam logic [1:0] CMD_DATA = 2'd0;
   localparam logic [1:0] CMD_STAT = 2'd1;

   // code 3 falls back to full speed
   localparam logic [1:0] SPEED_LS = 2'd0;
   localparam logic [1:0] SPEED_FS = 2'd1;
   localparam logic [1:0] SPEED_HS = 2'd2;

   //////////////////////////////////////////////////////////////////////
   // register map
   //////////////////////////////////////////////////////////////////////
   localparam logic [7:0] ADDR_ARM        = 8'h00;
   localparam logic [7:0] ADDR_SPEED      = 8'h01;
   localparam logic [7:0] ADDR_PATTERN0   = 8'h10;  // up to 0x13
   localparam logic [7:0] ADDR_MASK0      = 8'h14;  // up to 0x17
   localparam logic [7:0] ADDR_PAT_BYTES  = 8'h18;
   localparam logic [7:0] ADDR_TRIG_DELAY = 8'h20;
   localparam logic [7:0] ADDR_TRIG_WIDTH = 8'h21;
   localparam logic [7:0] ADDR_CAP_LEN    = 8'h22;
   localparam logic [7:0] ADDR_FIFO_B0    = 8'h30;
   localparam logic [7:0] ADDR_FIFO_B1    = 8'h31;
   localparam logic [7:0] ADDR_FIFO_B2    = 8'h32;  // read pops the head
   localparam logic [7:0] ADDR_FIFO_STAT  = 8'h33;

   // one capture word, seen as a byte entry or as a line status entry
   typedef struct packed {
      logic [1:0]          cmd;
      logic [TS_WIDTH-1:0] ts;
      logic [7:0]          rx_byte;
   } data_view_t;

   typedef struct packed {
      logic [1:0]            cmd;
      logic [TS_WIDTH-1:0]   ts;
      logic [2:0]            pad;
      logic [STAT_WIDTH-1:0] stat;
   } stat_view_t;

   typedef union packed {
      data_view_t data;
      stat_view_t status;
   } capture_entry_t;

endpackage
